/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard source/*.svh)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/rv_exec_tb.sv */
// rv exec testbench: directed APB tests of the RV32I execution subsystem against a model
`timescale 1ns/10ps
`default_nettype none
`include "rv_exec_config.svh"

module rv_exec_tb;
  import rv_isa_pkg::*;
  import rv_host_pkg::*;

  localparam int unsigned CLK_PERIOD  = 100;
  localparam int unsigned NUM_TESTS   = 6;
  localparam int unsigned MAX_XFERS   = 120;
  localparam int unsigned XFER_CYCLES = 8;

  // RV32I major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_IMMED  = 7'b0010011;
  localparam logic [6:0] OP_REGREG = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  // ADD SUB SLL SLT SLTU XOR SRL SRA OR AND, index 0 in the low bits
  localparam logic [29:0] RR_F3  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
  localparam logic [9:0]  RR_ALT = 10'b0010000010;

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;

  // expected architectural state
  word_t       exp_regs [`RV_NUM_REGS];
  word_t       exp_pc;
  logic [15:0] exp_retired;
  logic [7:0]  exp_illegal;
  logic        exp_ecall;
  logic        exp_ebreak;
  logic        exp_unsup;
  int unsigned errors;
  int unsigned checks;

  rv_exec_top uut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (NUM_TESTS * MAX_XFERS * XFER_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * MAX_XFERS * XFER_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_value(input string name, input word_t got, input word_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, want);
    end
  endtask

  // starts on a falling edge, ends on the falling edge after the completing edge
  task automatic apb_xfer(input logic write, input apb_addr_t addr, input word_t wdata,
                          output word_t rdata, output logic slverr);
    apb_req.paddr   = addr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #(CLK_PERIOD / 4);
    while (!apb_rsp.pready) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input word_t data, output logic slverr);
    word_t unused;
    apb_xfer(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input apb_addr_t addr, output word_t data, output logic slverr);
    apb_xfer(1'b0, addr, '0, data, slverr);
  endtask

  function automatic apb_addr_t reg_addr(input reg_idx_t idx);
    return `RV_ADDR_REG_BASE + {5'b0, idx, 2'b00};
  endfunction

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'(1 + ($urandom() % 31));
  endfunction

  // instruction encodings
  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  // RV32I integer result by funct3, alt selects SUB and SRA
  function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    logic signed [31:0] sa;
    sa = $signed(a) >>> b[4:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'(sa) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // synchronous reset, expected state back to its reset values
  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n       = 1'b1;
    exp_pc      = '0;
    exp_retired = '0;
    exp_illegal = '0;
    exp_ecall   = 1'b0;
    exp_ebreak  = 1'b0;
    exp_unsup   = 1'b0;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      exp_regs[i] = '0;
    end
  endtask

  task automatic write_reg(input reg_idx_t idx, input word_t val);
    logic err;
    apb_write(reg_addr(idx), val, err);
    check_value("pslverr", word_t'(err), '0);
    exp_regs[idx] = val;
  endtask

  task automatic check_reg(input reg_idx_t idx);
    word_t rdata;
    logic  err;
    apb_read(reg_addr(idx), rdata, err);
    check_value("pslverr", word_t'(err), '0);
    check_value($sformatf("x%0d", idx), rdata, exp_regs[idx]);
  endtask

  task automatic check_state();
    word_t rdata;
    logic  err;
    apb_read(`RV_ADDR_STATUS, rdata, err);
    check_value("pslverr", word_t'(err), '0);
    check_value("status", rdata,
                {5'b0, exp_unsup, exp_ebreak, exp_ecall, exp_illegal, exp_retired});
    apb_read(`RV_ADDR_PC, rdata, err);
    check_value("pslverr", word_t'(err), '0);
    check_value("pc", rdata, exp_pc);
  endtask

  // every issued word retires and advances the PC
  task automatic issue(input word_t instr);
    logic err;
    apb_write(`RV_ADDR_INSTR, instr, err);
    check_value("pslverr", word_t'(err), '0);
    exp_pc      = exp_pc + 32'd4;
    exp_retired = exp_retired + 16'd1;
  endtask

  task automatic bump_illegal();
    if (exp_illegal != 8'hff) begin
      exp_illegal = exp_illegal + 8'd1;
    end
  endtask

  // starts from reset so the sticky flag shows this class alone
  task automatic run_unsupported(input word_t instr);
    reset_dut();
    write_reg(5'd20, 32'hdead_beef);
    write_reg(5'd21, 32'h0000_0013);
    issue(instr);
    exp_unsup = 1'b1;
    check_reg(5'd20);
    check_state();
  endtask

  task automatic run_rr(input logic [2:0] f3, input logic alt, input reg_idx_t rs1,
                        input reg_idx_t rs2, input reg_idx_t rd);
    word_t result;
    result = model_alu(f3, alt, exp_regs[rs1], exp_regs[rs2]);
    issue(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OP_REGREG));
    if (rd != '0) begin
      exp_regs[rd] = result;
    end
    check_reg(rd);
    check_state();
  endtask

  // shifts take shamt from imm 4:0, imm bit 10 is instruction bit 30
  task automatic run_immed(input logic [2:0] f3, input logic [11:0] imm, input reg_idx_t rs1,
                           input reg_idx_t rd);
    word_t b;
    word_t result;
    b = (f3 == 3'd1 || f3 == 3'd5) ? word_t'(imm[4:0]) : {{20{imm[11]}}, imm};
    result = model_alu(f3, (f3 == 3'd5) && imm[10], exp_regs[rs1], b);
    issue(enc_i(imm, rs1, f3, rd, OP_IMMED));
    if (rd != '0) begin
      exp_regs[rd] = result;
    end
    check_reg(rd);
    check_state();
  endtask

  task automatic test_reset();
    check_state();
    check_reg(5'd0);
    for (int i = 0; i < 4; i++) begin
      check_reg(rand_reg());
    end
  endtask

  task automatic test_regreg();
    reg_idx_t rs1;
    reg_idx_t rs2;
    for (int i = 0; i < 10; i++) begin
      rs1 = rand_reg();
      rs2 = rand_reg();
      write_reg(rs1, $urandom());
      write_reg(rs2, $urandom());
      run_rr(RR_F3[3*i +: 3], RR_ALT[i], rs1, rs2, rand_reg());
    end
  endtask

  task automatic test_immed();
    reg_idx_t rs1;
    reg_idx_t rd;
    word_t    pc_val;
    word_t    result;
    logic     err;
    rs1 = rand_reg();
    // rd apart from rs1 so the source keeps its value
    rd  = (rs1 == 5'd31) ? 5'd1 : rs1 + 5'd1;
    write_reg(rs1, $urandom());
    run_immed(3'd0, 12'hf9c, rs1, rd);
    run_immed(3'd2, 12'hfff, rs1, rd);
    run_immed(3'd3, 12'hfff, rs1, rd);
    run_immed(3'd4, 12'h8a5, rs1, rd);
    run_immed(3'd6, 12'h0f0, rs1, rd);
    run_immed(3'd7, 12'hf0f, rs1, rd);
    // sign bit set so SRAI and SRLI differ
    write_reg(rs1, 32'h8765_4321);
    run_immed(3'd1, 12'h007, rs1, rd);
    run_immed(3'd5, 12'h00d, rs1, rd);
    run_immed(3'd5, 12'h40d, rs1, rd);
    issue(enc_u(20'habcde, rd, OP_LUI));
    exp_regs[rd] = 32'habcd_e000;
    check_reg(rd);
    check_state();
    pc_val = $urandom() & 32'hffff_fffc;
    apb_write(`RV_ADDR_PC, pc_val, err);
    check_value("pslverr", word_t'(err), '0);
    exp_pc = pc_val;
    check_state();
    result = exp_pc + 32'h1234_5000;
    issue(enc_u(20'h12345, rd, OP_AUIPC));
    exp_regs[rd] = result;
    check_reg(rd);
    check_state();
    // x0 as destination
    run_immed(3'd0, 12'h123, rs1, 5'd0);
    issue(enc_u(20'hfffff, 5'd0, OP_LUI));
    check_reg(5'd0);
  endtask

  // each instruction reads the rd of the one before, read right after issue
  task automatic test_chain();
    reg_idx_t prev;
    reg_idx_t rd;
    write_reg(5'd5, $urandom());
    prev = 5'd5;
    for (int i = 0; i < 8; i++) begin
      rd = reg_idx_t'(6 + i);
      if (i % 2 == 0) begin
        run_immed(3'(i), 12'($urandom()), prev, rd);
      end else begin
        run_rr(3'(i), i == 5, prev, 5'd5, rd);
      end
      prev = rd;
    end
  endtask

  task automatic test_exceptions();
    write_reg(5'd20, 32'hdead_beef);
    write_reg(5'd21, 32'h0000_0013);
    issue(enc_r(7'h03, 5'd21, 5'd21, 3'd0, 5'd20, OP_REGREG));
    bump_illegal();
    check_reg(5'd20);
    check_state();
    issue(enc_r(7'h00, 5'd21, 5'd21, 3'd0, 5'd20, 7'b1111111));
    bump_illegal();
    check_reg(5'd20);
    check_state();
    issue(enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'b1110011));
    exp_ecall = 1'b1;
    check_state();
    issue(enc_i(12'h001, 5'd0, 3'd0, 5'd0, 7'b1110011));
    exp_ebreak = 1'b1;
    check_state();
    run_unsupported(enc_r(7'h01, 5'd21, 5'd21, 3'd0, 5'd20, OP_REGREG));
    run_unsupported(enc_i(12'h010, 5'd21, 3'b010, 5'd20, OP_LOAD));
    run_unsupported(enc_r(7'h00, 5'd21, 5'd20, 3'd0, 5'd20, OP_BRANCH));
  endtask

  task automatic test_bus_errors();
    word_t rdata;
    logic  err;
    apb_write(`RV_ADDR_STATUS, 32'hffff_ffff, err);
    check_value("pslverr", word_t'(err), 32'd1);
    apb_write(reg_addr(5'd0), $urandom(), err);
    check_value("pslverr", word_t'(err), 32'd1);
    apb_write(12'h00c, $urandom(), err);
    check_value("pslverr", word_t'(err), 32'd1);
    // misaligned inside the x1 word
    apb_write(12'h106, $urandom(), err);
    check_value("pslverr", word_t'(err), 32'd1);
    apb_read(12'h080, rdata, err);
    check_value("pslverr", word_t'(err), 32'd1);
    check_reg(5'd0);
    check_reg(5'd1);
    check_state();
  endtask

  initial begin
    void'($urandom(32'hb487));
    rst_n   = 1'b0;
    apb_req = '0;
    errors  = 0;
    checks  = 0;
    reset_dut();
    test_reset();
    test_regreg();
    test_immed();
    test_chain();
    test_exceptions();
    test_bus_errors();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/apb_issue_port.sv */
// apb issue port: APB slave that issues instruction words and stalls until they commit
`timescale 1ns/10ps
`default_nettype none
`include "rv_exec_config.svh"

module apb_issue_port (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire rv_host_pkg::apb_req_t apb_req_i,
  output rv_host_pkg::apb_rsp_t      apb_rsp_o,
  output logic                       issue_valid_o,
  output rv_isa_pkg::word_t          issue_instr_o,
  output rv_host_pkg::host_wr_t      host_wr_o,
  output rv_isa_pkg::reg_idx_t       rd_idx_o,
  input  wire rv_isa_pkg::word_t     rd_data_i,
  input  wire rv_host_pkg::status_t  status_i,
  input  wire rv_isa_pkg::word_t     pc_i
);
  import rv_isa_pkg::*;
  import rv_host_pkg::*;

  localparam int unsigned LAT_W = $clog2(`RV_EXEC_LATENCY + 1);

  issue_state_t     state_q;
  logic [LAT_W-1:0] lat_cnt_q;
  word_t            instr_q;
  apb_addr_t        reg_off;
  logic             hit_instr;
  logic             hit_status;
  logic             hit_pc;
  logic             hit_reg;
  logic             err;
  logic             ready;
  logic             done;
  logic             issue_fire;

  // address map
  assign hit_instr  = (apb_req_i.paddr == `RV_ADDR_INSTR);
  assign hit_status = (apb_req_i.paddr == `RV_ADDR_STATUS);
  assign hit_pc     = (apb_req_i.paddr == `RV_ADDR_PC);
  assign reg_off    = apb_req_i.paddr - `RV_ADDR_REG_BASE;
  assign hit_reg    = (apb_req_i.paddr >= `RV_ADDR_REG_BASE) &&
                      (reg_off < 4 * `RV_NUM_REGS) && (reg_off[1:0] == 2'b00);
  assign rd_idx_o   = reg_idx_t'(reg_off >> 2);

  // unmapped, or a write to a read-only location
  assign err = !(hit_instr || hit_status || hit_pc || hit_reg) ||
               (apb_req_i.pwrite && (hit_status || (hit_reg && rd_idx_o == '0)));

  assign ready      = (state_q == ST_IDLE);
  assign done       = apb_req_i.psel && apb_req_i.penable && ready;
  assign issue_fire = done && apb_req_i.pwrite && hit_instr;

  always_comb begin
    apb_rsp_o.pready  = ready;
    apb_rsp_o.pslverr = done && err;
    if (hit_status) begin
      apb_rsp_o.prdata = status_i;
    end else if (hit_pc) begin
      apb_rsp_o.prdata = pc_i;
    end else if (hit_reg) begin
      apb_rsp_o.prdata = rd_data_i;
    end else if (hit_instr) begin
      apb_rsp_o.prdata = instr_q;
    end else begin
      apb_rsp_o.prdata = '0;
    end
  end

  // PC and register writes go straight to writeback
  always_comb begin
    host_wr_o.valid  = done && apb_req_i.pwrite && !err && (hit_pc || hit_reg);
    host_wr_o.target = hit_pc ? HW_PC : HW_REG;
    host_wr_o.idx    = rd_idx_o;
    host_wr_o.data   = apb_req_i.pwdata;
  end

  // busy from issue until the commit edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= ST_IDLE;
      lat_cnt_q     <= '0;
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= issue_fire;
      case (state_q)
        ST_IDLE: begin
          if (issue_fire) begin
            state_q   <= ST_BUSY;
            lat_cnt_q <= LAT_W'(`RV_EXEC_LATENCY - 1);
          end
        end
        ST_BUSY: begin
          if (lat_cnt_q == '0) begin
            state_q <= ST_IDLE;
          end else begin
            lat_cnt_q <= lat_cnt_q - 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      instr_q <= apb_req_i.pwdata;
    end
  end

  assign issue_instr_o = instr_q;

  // one instruction in flight
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_o |=> !issue_valid_o);

  // bus still held off in the commit cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(issue_valid_o, `RV_EXEC_LATENCY - 1) |-> !apb_rsp_o.pready);

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
// instruction decoder: classes RV32I words, builds operands and registers the decoded op
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     issue_valid_i,
  input  wire rv_isa_pkg::word_t  issue_instr_i,
  output rv_isa_pkg::reg_idx_t    rs1_idx_o,
  output rv_isa_pkg::reg_idx_t    rs2_idx_o,
  input  wire rv_isa_pkg::word_t  rs1_data_i,
  input  wire rv_isa_pkg::word_t  rs2_data_i,
  input  wire rv_isa_pkg::word_t  pc_i,
  output logic                    dec_valid_o,
  output rv_isa_pkg::decoded_op_t dec_o
);
  import rv_isa_pkg::*;

  rtype_t      instr_r;
  itype_t      instr_i;
  opcode_t     opcode;
  word_t       imm_i;
  word_t       imm_u;
  logic        sr;
  logic        add_sub;
  logic        aluop_sll, aluop_sra, aluop_srl, aluop_add, aluop_sub;
  logic        aluop_and, aluop_or, aluop_xor, aluop_slt, aluop_sltu;
  logic        is_priv;
  logic        is_muldiv;
  logic        executed;
  logic        illegal;
  decoded_op_t dec_d;

  assign instr_r = rtype_t'(issue_instr_i);
  assign instr_i = itype_t'(issue_instr_i);
  assign opcode  = opcode_t'(issue_instr_i[6:0]);

  assign imm_i     = {{20{instr_i.imm11_00[11]}}, instr_i.imm11_00};
  assign imm_u     = {issue_instr_i[31:12], 12'b0};

  assign rs1_idx_o = instr_r.rs1;
  assign rs2_idx_o = instr_r.rs2;

  // ALU op flags, IMMED and REGREG share funct3
  assign sr      = (opcode == IMMED || opcode == REGREG) && instr_r.funct3 == F3_SR;
  assign add_sub = (opcode == REGREG) && instr_r.funct3 == F3_ADDSUB;

  assign aluop_sll  = (opcode == IMMED || opcode == REGREG) && instr_r.funct3 == F3_SLL;
  assign aluop_sra  = sr && issue_instr_i[30];
  assign aluop_srl  = sr && !issue_instr_i[30];
  assign aluop_add  = (opcode == IMMED && instr_i.funct3 == F3_ADDSUB) ||
                      (opcode == AUIPC) || (add_sub && !issue_instr_i[30]);
  assign aluop_sub  = add_sub && issue_instr_i[30];
  assign aluop_and  = (opcode == IMMED || opcode == REGREG) && instr_r.funct3 == F3_AND;
  assign aluop_or   = (opcode == IMMED || opcode == REGREG) && instr_r.funct3 == F3_OR;
  assign aluop_xor  = (opcode == IMMED || opcode == REGREG) && instr_r.funct3 == F3_XOR;
  assign aluop_slt  = (opcode == IMMED || opcode == REGREG) && instr_r.funct3 == F3_SLT;
  assign aluop_sltu = (opcode == IMMED || opcode == REGREG) && instr_r.funct3 == F3_SLTU;

  // odd funct7 other than the M extension, or an opcode outside the base set
  always_comb begin
    case (opcode)
      REGREG: illegal = instr_r.funct7[0] && (instr_r.funct7 != 7'b000_0001);
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD,
      STORE, IMMED, MISCMEM, SYSTEM: illegal = 1'b0;
      default: illegal = 1'b1;
    endcase
  end

  assign is_priv   = (opcode == SYSTEM) && (instr_i.funct3 == F3_PRIV);
  assign is_muldiv = (opcode == REGREG) && (instr_r.funct7 == 7'b000_0001);
  assign executed  = !illegal && ((opcode == REGREG && !is_muldiv) ||
                                  opcode == IMMED || opcode == LUI || opcode == AUIPC);

  always_comb begin
    dec_d.rd          = instr_r.rd;
    dec_d.illegal     = illegal;
    dec_d.ecall       = is_priv && (instr_i.imm11_00 == PRIV_ECALL);
    dec_d.ebreak      = is_priv && (instr_i.imm11_00 == PRIV_EBREAK);
    dec_d.unsupported = !illegal && !executed && !dec_d.ecall && !dec_d.ebreak;
    dec_d.wen         = executed && (instr_r.rd != '0);

    if (aluop_sll) begin
      dec_d.alu_op = ALU_SLL;
    end else if (aluop_sra) begin
      dec_d.alu_op = ALU_SRA;
    end else if (aluop_srl) begin
      dec_d.alu_op = ALU_SRL;
    end else if (aluop_add) begin
      dec_d.alu_op = ALU_ADD;
    end else if (aluop_sub) begin
      dec_d.alu_op = ALU_SUB;
    end else if (aluop_and) begin
      dec_d.alu_op = ALU_AND;
    end else if (aluop_or) begin
      dec_d.alu_op = ALU_OR;
    end else if (aluop_xor) begin
      dec_d.alu_op = ALU_XOR;
    end else if (aluop_slt) begin
      dec_d.alu_op = ALU_SLT;
    end else if (aluop_sltu) begin
      dec_d.alu_op = ALU_SLTU;
    end else if (opcode == LUI) begin
      dec_d.alu_op = ALU_PASS_B;
    end else begin
      dec_d.alu_op = ALU_ADD;
    end

    // operand sources per class
    case (opcode)
      IMMED: begin
        // shifts take shamt from imm 4:0
        dec_d.op_a = rs1_data_i;
        dec_d.op_b = imm_i;
      end
      LUI: begin
        dec_d.op_a = '0;
        dec_d.op_b = imm_u;
      end
      AUIPC: begin
        dec_d.op_a = pc_i;
        dec_d.op_b = imm_u;
      end
      default: begin
        dec_d.op_a = rs1_data_i;
        dec_d.op_b = rs2_data_i;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      dec_o <= dec_d;
    end
  end

  // at most one outcome per decoded word
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_o |-> $onehot0({dec_o.illegal, dec_o.ecall, dec_o.ebreak,
                              dec_o.unsupported, dec_o.wen}));

endmodule

`default_nettype wire

/* source/int_exec_unit.sv */
// int exec unit: RV32I integer ALU forming the writeback record
`timescale 1ns/10ps
`default_nettype none

module int_exec_unit (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire                          dec_valid_i,
  input  wire rv_isa_pkg::decoded_op_t dec_i,
  output rv_isa_pkg::wb_rec_t          wb_o
);
  import rv_isa_pkg::*;

  word_t  op_a;
  word_t  op_b;
  shamt_t shamt;
  word_t  result;

  assign op_a  = dec_i.op_a;
  assign op_b  = dec_i.op_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   result = word_t'(op_a < op_b);
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // record is consumed by writeback on this same cycle
  always_comb begin
    wb_o.valid       = dec_valid_i;
    wb_o.rd          = dec_i.rd;
    wb_o.wen         = dec_i.wen;
    wb_o.result      = result;
    wb_o.illegal     = dec_i.illegal;
    wb_o.ecall       = dec_i.ecall;
    wb_o.ebreak      = dec_i.ebreak;
    wb_o.unsupported = dec_i.unsupported;
  end

  // the issue stall keeps decoded ops at least two cycles apart
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_i |=> !dec_valid_i);

endmodule

`default_nettype wire

/* source/reg_writeback.sv */
// reg writeback: register file, PC, retire and illegal counters, sticky status flags
`timescale 1ns/10ps
`default_nettype none
`include "rv_exec_config.svh"

module reg_writeback (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  input  wire rv_isa_pkg::wb_rec_t    wb_i,
  input  wire rv_host_pkg::host_wr_t  host_wr_i,
  input  wire rv_isa_pkg::reg_idx_t   rs1_idx_i,
  input  wire rv_isa_pkg::reg_idx_t   rs2_idx_i,
  input  wire rv_isa_pkg::reg_idx_t   rd_idx_i,
  output rv_isa_pkg::word_t           rs1_data_o,
  output rv_isa_pkg::word_t           rs2_data_o,
  output rv_isa_pkg::word_t           rd_data_o,
  output rv_isa_pkg::word_t           pc_o,
  output rv_host_pkg::status_t        status_o
);
  import rv_isa_pkg::*;
  import rv_host_pkg::*;

  word_t        regs_q [`RV_NUM_REGS];
  word_t        pc_q;
  retire_cnt_t  retired_q;
  illegal_cnt_t illegal_q;
  logic         ecall_q;
  logic         ebreak_q;
  logic         unsup_q;

  // x0 is never written so it reads zero
  assign rs1_data_o = regs_q[rs1_idx_i];
  assign rs2_data_o = regs_q[rs2_idx_i];
  assign rd_data_o  = regs_q[rd_idx_i];
  assign pc_o       = pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
      pc_q      <= '0;
      retired_q <= '0;
      illegal_q <= '0;
      ecall_q   <= 1'b0;
      ebreak_q  <= 1'b0;
      unsup_q   <= 1'b0;
    end else begin
      if (host_wr_i.valid) begin
        if (host_wr_i.target == HW_PC) begin
          pc_q <= host_wr_i.data;
        end else if (host_wr_i.idx != '0) begin
          regs_q[host_wr_i.idx] <= host_wr_i.data;
        end
      end
      // commit, illegal words retire too
      if (wb_i.valid) begin
        if (wb_i.wen && wb_i.rd != '0) begin
          regs_q[wb_i.rd] <= wb_i.result;
        end
        pc_q      <= pc_q + word_t'(4);
        retired_q <= retired_q + 1'b1;
        if (wb_i.illegal && illegal_q != '1) begin
          illegal_q <= illegal_q + 1'b1;
        end
        ecall_q  <= ecall_q | wb_i.ecall;
        ebreak_q <= ebreak_q | wb_i.ebreak;
        unsup_q  <= unsup_q | wb_i.unsupported;
      end
    end
  end

  always_comb begin
    status_o.reserved    = '0;
    status_o.unsupported = unsup_q;
    status_o.ebreak      = ebreak_q;
    status_o.ecall       = ecall_q;
    status_o.illegal_cnt = illegal_q;
    status_o.retired_cnt = retired_q;
  end

  // host writes only land while the issue port is idle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_wr_i.valid && wb_i.valid));

endmodule

`default_nettype wire

/* source/rv_exec_config.svh */
// rv exec config: widths, register count, APB register map and pipeline latency
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

`define RV_XLEN          32
`define RV_NUM_REGS      32
`define RV_APB_ADDR_W    12

// APB map, registers x0..x31 at base + 4 * index
`define RV_ADDR_INSTR    12'h000
`define RV_ADDR_STATUS   12'h004
`define RV_ADDR_PC       12'h008
`define RV_ADDR_REG_BASE 12'h100

// cycles from issue to commit
`define RV_EXEC_LATENCY  2

`endif

/* source/rv_exec_top.sv */
// rv exec top: APB issue port, decoder, integer execute and writeback wired together
`timescale 1ns/10ps
`default_nettype none

module rv_exec_top (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire rv_host_pkg::apb_req_t apb_req_i,
  output rv_host_pkg::apb_rsp_t      apb_rsp_o
);
  import rv_isa_pkg::*;
  import rv_host_pkg::*;

  logic        issue_valid;
  word_t       issue_instr;
  host_wr_t    host_wr;
  reg_idx_t    rd_idx;
  reg_idx_t    rs1_idx;
  reg_idx_t    rs2_idx;
  word_t       rd_data;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       pc;
  status_t     status;
  logic        dec_valid;
  decoded_op_t dec;
  wb_rec_t     wb;

  // input side
  apb_issue_port u_issue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .issue_valid_o (issue_valid),
    .issue_instr_o (issue_instr),
    .host_wr_o     (host_wr),
    .rd_idx_o      (rd_idx),
    .rd_data_i     (rd_data),
    .status_i      (status),
    .pc_i          (pc)
  );

  instr_decoder u_decode (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid),
    .issue_instr_i (issue_instr),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .pc_i          (pc),
    .dec_valid_o   (dec_valid),
    .dec_o         (dec)
  );

  int_exec_unit u_exec (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .wb_o        (wb)
  );

  // output side
  reg_writeback u_wb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_i       (wb),
    .host_wr_i  (host_wr),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rd_idx_i   (rd_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .rd_data_o  (rd_data),
    .pc_o       (pc),
    .status_o   (status)
  );

endmodule

`default_nettype wire

/* source/rv_host_pkg.sv */
// rv host package: APB bus records, status word and host write path types
`default_nettype none
`include "rv_exec_config.svh"

package rv_host_pkg;

  typedef logic [`RV_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [15:0]               retire_cnt_t;
  typedef logic [7:0]                illegal_cnt_t;

  typedef struct packed {
    apb_addr_t         paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    rv_isa_pkg::word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    rv_isa_pkg::word_t prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // STATUS register layout
  typedef struct packed {
    logic [4:0]   reserved;
    logic         unsupported;
    logic         ebreak;
    logic         ecall;
    illegal_cnt_t illegal_cnt;
    retire_cnt_t  retired_cnt;
  } status_t;

  typedef enum logic {ST_IDLE, ST_BUSY} issue_state_t;

  typedef enum logic {HW_PC, HW_REG} host_tgt_t;

  typedef struct packed {
    logic                 valid;
    host_tgt_t            target;
    rv_isa_pkg::reg_idx_t idx;
    rv_isa_pkg::word_t    data;
  } host_wr_t;

endpackage

`default_nettype wire

/* source/rv_isa_pkg.sv */
// rv isa package: RV32I opcodes, instruction formats, ALU ops and pipeline records
`default_nettype none
`include "rv_exec_config.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [4:0]          shamt_t;
  typedef logic [2:0]          funct3_t;

  // major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  // funct3 codes, shared by the IMMED and REGREG classes
  localparam funct3_t F3_ADDSUB = 3'b000;
  localparam funct3_t F3_SLL    = 3'b001;
  localparam funct3_t F3_SLT    = 3'b010;
  localparam funct3_t F3_SLTU   = 3'b011;
  localparam funct3_t F3_XOR    = 3'b100;
  localparam funct3_t F3_SR     = 3'b101;
  localparam funct3_t F3_OR     = 3'b110;
  localparam funct3_t F3_AND    = 3'b111;
  localparam funct3_t F3_PRIV   = 3'b000;

  // imm field of privileged SYSTEM words
  localparam logic [11:0] PRIV_ECALL  = 12'h000;
  localparam logic [11:0] PRIV_EBREAK = 12'h001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    funct3_t    funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    reg_idx_t    rs1;
    funct3_t     funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } itype_t;

  // decoder to execute
  typedef struct packed {
    alu_op_t  alu_op;
    word_t    op_a;
    word_t    op_b;
    reg_idx_t rd;
    logic     wen;
    logic     illegal;
    logic     ecall;
    logic     ebreak;
    logic     unsupported;
  } decoded_op_t;

  // execute to writeback
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    logic     wen;
    word_t    result;
    logic     illegal;
    logic     ecall;
    logic     ebreak;
    logic     unsupported;
  } wb_rec_t;

endpackage

`default_nettype wire

/* sources.f */
+incdir+source
source/rv_isa_pkg.sv
source/rv_host_pkg.sv
source/apb_issue_port.sv
source/instr_decoder.sv
source/int_exec_unit.sv
source/reg_writeback.sv
source/rv_exec_top.sv
bench/rv_exec_tb.sv
